//--- rtl/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// widths
`define CSR_NUM_W   14
`define CSR_DATA_W  32
`define LIE_W       13

// register numbers
`define CSR_CRMD    14'h000
`define CSR_PRMD    14'h001
`define CSR_ECFG    14'h004
`define CSR_ESTAT   14'h005
`define CSR_ERA     14'h006
`define CSR_BADV    14'h007
`define CSR_EENTRY  14'h00c
`define CSR_SAVE0   14'h030
`define CSR_SAVE1   14'h031
`define CSR_SAVE2   14'h032
`define CSR_SAVE3   14'h033
`define CSR_TID     14'h040
`define CSR_TCFG    14'h041
`define CSR_TVAL    14'h042
`define CSR_TICLR   14'h044

// exception codes
`define ECODE_ADE      6'h08
`define ECODE_ALE      6'h09
`define ESUBCODE_ADEF  9'h000

// field positions
`define TIMER_IS_BIT   11
`define EENTRY_VA_LSB  6
`define TICLR_CLR_BIT  0
`define IS_SW_W        2

`endif

//--- rtl/csr_decode.sv
`include "csr_config.svh"
`timescale 1ns/100ps
`default_nettype none

module csr_decode (
    input  logic                  wr_en,
    input  logic [`CSR_NUM_W-1:0] wnum,
    input  logic [`CSR_NUM_W-1:0] rnum,
    output csr_pkg::csr_sel_t     wsel,
    output csr_pkg::csr_sel_t     rsel
);

    // unknown numbers select nothing
    function automatic csr_pkg::csr_sel_t num_to_sel(input logic [`CSR_NUM_W-1:0] num);
        csr_pkg::csr_sel_t sel;
        sel = '0;
        case (num)
            `CSR_CRMD:   sel.crmd   = 1'b1;
            `CSR_PRMD:   sel.prmd   = 1'b1;
            `CSR_ECFG:   sel.ecfg   = 1'b1;
            `CSR_ESTAT:  sel.estat  = 1'b1;
            `CSR_ERA:    sel.era    = 1'b1;
            `CSR_BADV:   sel.badv   = 1'b1;
            `CSR_EENTRY: sel.eentry = 1'b1;
            `CSR_SAVE0:  sel.save0  = 1'b1;
            `CSR_SAVE1:  sel.save1  = 1'b1;
            `CSR_SAVE2:  sel.save2  = 1'b1;
            `CSR_SAVE3:  sel.save3  = 1'b1;
            `CSR_TID:    sel.tid    = 1'b1;
            `CSR_TCFG:   sel.tcfg   = 1'b1;
            `CSR_TVAL:   sel.tval   = 1'b1;
            `CSR_TICLR:  sel.ticlr  = 1'b1;
            default:     sel        = '0;
        endcase
        return sel;
    endfunction

    // write select only while a write is requested
    assign wsel = wr_en ? num_to_sel(wnum) : '0;
    assign rsel = num_to_sel(rnum);

endmodule

`default_nettype wire

//--- rtl/csr_exc_state.sv
`include "csr_config.svh"
`timescale 1ns/100ps
`default_nettype none

module csr_exc_state (
    input  logic                     clk,
    input  logic                     rst,
    input  csr_pkg::csr_wr_t         wr,
    input  csr_pkg::csr_sel_t        wsel,
    input  csr_pkg::exc_commit_t     commit,
    input  logic                     ertn,
    input  logic                     timer_int,
    output csr_pkg::exc_state_t      state,
    output logic                     has_int,
    output logic [`CSR_DATA_W-1:0]   exc_entry,
    output logic [`CSR_DATA_W-1:0]   exc_retaddr,
    output logic [1:0]               crmd_plv
);

    csr_pkg::csr_word_u wset;
    csr_pkg::csr_word_u wkeep;
    csr_pkg::crmd_t     crmd_q;
    csr_pkg::prmd_t     prmd_q;
    logic [`LIE_W-1:0]                     ecfg_lie;
    logic [`IS_SW_W-1:0]                   is_sw;
    logic [`LIE_W-1:0]                     is_vec;
    logic [5:0]                            ecode_q;
    logic [8:0]                            esubcode_q;
    logic [`CSR_DATA_W-1:0]                era_q;
    logic [`CSR_DATA_W-1:0]                badv_q;
    logic [`CSR_DATA_W-`EENTRY_VA_LSB-1:0] eentry_va;
    logic [3:0][`CSR_DATA_W-1:0]           save_q;
    logic [3:0]                            save_we;
    logic                                  badv_from_pc;
    logic                                  badv_from_addr;

    // masked merge is wset | wkeep & old
    assign wset.raw  = wr.wmask & wr.wval;
    assign wkeep.raw = ~wr.wmask;

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_q <= '0;
        end else if (commit.exc) begin
            crmd_q <= '0;
        end else if (ertn) begin
            crmd_q.plv <= prmd_q.pplv;
            crmd_q.ie  <= prmd_q.pie;
        end else if (wsel.crmd) begin
            crmd_q.plv <= wset.crmd.plv | wkeep.crmd.plv & crmd_q.plv;
            crmd_q.ie  <= wset.crmd.ie | wkeep.crmd.ie & crmd_q.ie;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_q <= '0;
        end else if (commit.exc) begin
            prmd_q.pplv <= crmd_q.plv;
            prmd_q.pie  <= crmd_q.ie;
        end else if (wsel.prmd) begin
            prmd_q.pplv <= wset.prmd.pplv | wkeep.prmd.pplv & prmd_q.pplv;
            prmd_q.pie  <= wset.prmd.pie | wkeep.prmd.pie & prmd_q.pie;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ecfg_lie  <= '0;
            is_sw     <= '0;
            eentry_va <= '0;
        end else begin
            if (wsel.ecfg) begin
                ecfg_lie <= wset.raw[`LIE_W-1:0] | wkeep.raw[`LIE_W-1:0] & ecfg_lie;
            end
            if (wsel.estat) begin
                is_sw <= wset.estat.is[`IS_SW_W-1:0] | wkeep.estat.is[`IS_SW_W-1:0] & is_sw;
            end
            if (wsel.eentry) begin
                eentry_va <= wset.raw[`CSR_DATA_W-1:`EENTRY_VA_LSB]
                           | wkeep.raw[`CSR_DATA_W-1:`EENTRY_VA_LSB] & eentry_va;
            end
        end
    end

    // ecode, esubcode and era from the faulting instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            ecode_q    <= '0;
            esubcode_q <= '0;
            era_q      <= '0;
        end else if (commit.exc) begin
            ecode_q    <= commit.ecode;
            esubcode_q <= commit.esubcode;
            era_q      <= commit.pc;
        end else if (wsel.era) begin
            era_q <= wset.raw | wkeep.raw & era_q;
        end
    end

    assign badv_from_pc   = commit.ecode == `ECODE_ADE && commit.esubcode == `ESUBCODE_ADEF;
    assign badv_from_addr = commit.ecode == `ECODE_ALE;

    always_ff @(posedge clk) begin
        if (rst) begin
            badv_q <= '0;
        end else if (commit.exc) begin
            if (badv_from_pc) begin
                badv_q <= commit.pc;
            end else if (badv_from_addr) begin
                badv_q <= commit.badvaddr;
            end
        end else if (wsel.badv) begin
            badv_q <= wset.raw | wkeep.raw & badv_q;
        end
    end

    assign save_we = {wsel.save3, wsel.save2, wsel.save1, wsel.save0};

    always_ff @(posedge clk) begin
        if (rst) begin
            save_q <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (save_we[i]) begin
                    save_q[i] <= wset.raw | wkeep.raw & save_q[i];
                end
            end
        end
    end

    // hardware lines and ipi stay zero
    always_comb begin
        is_vec                = '0;
        is_vec[`IS_SW_W-1:0]  = is_sw;
        is_vec[`TIMER_IS_BIT] = timer_int;
    end

    assign state.crmd           = crmd_q;
    assign state.prmd           = prmd_q;
    assign state.ecfg_lie       = ecfg_lie;
    assign state.estat.is       = is_vec;
    assign state.estat.ecode    = ecode_q;
    assign state.estat.esubcode = esubcode_q;
    assign state.era            = era_q;
    assign state.badv           = badv_q;
    assign state.eentry_va      = eentry_va;
    assign state.save           = save_q;

    assign has_int     = (|(is_vec & ecfg_lie)) & crmd_q.ie;
    assign exc_entry   = {eentry_va, {`EENTRY_VA_LSB{1'b0}}};
    assign exc_retaddr = era_q;
    assign crmd_plv    = crmd_q.plv;

endmodule

`default_nettype wire

//--- rtl/csr_pkg.sv
`include "csr_config.svh"
`default_nettype none

package csr_pkg;

    typedef struct packed {
        logic                   we;
        logic [`CSR_NUM_W-1:0]  wnum;
        logic [`CSR_DATA_W-1:0] wmask;
        logic [`CSR_DATA_W-1:0] wval;
    } csr_wr_t;

    typedef struct packed {
        logic                   exc;
        logic [5:0]             ecode;
        logic [8:0]             esubcode;
        logic [`CSR_DATA_W-1:0] pc;
        logic [`CSR_DATA_W-1:0] badvaddr;
    } exc_commit_t;

    // one bit per kept register
    typedef struct packed {
        logic crmd;
        logic prmd;
        logic ecfg;
        logic estat;
        logic era;
        logic badv;
        logic eentry;
        logic save0;
        logic save1;
        logic save2;
        logic save3;
        logic tid;
        logic tcfg;
        logic tval;
        logic ticlr;
    } csr_sel_t;

    typedef struct packed {
        logic [28:0] rsvd;
        logic        ie;
        logic [1:0]  plv;
    } crmd_view_t;

    typedef struct packed {
        logic [28:0] rsvd;
        logic        pie;
        logic [1:0]  pplv;
    } prmd_view_t;

    typedef struct packed {
        logic              rsvd1;
        logic [8:0]        esubcode;
        logic [5:0]        ecode;
        logic [2:0]        rsvd0;
        logic [`LIE_W-1:0] is;
    } estat_view_t;

    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_view_t;

    typedef union packed {
        logic [`CSR_DATA_W-1:0] raw;
        crmd_view_t             crmd;
        prmd_view_t             prmd;
        estat_view_t            estat;
        tcfg_view_t             tcfg;
    } csr_word_u;

    typedef struct packed {
        logic       ie;
        logic [1:0] plv;
    } crmd_t;

    typedef struct packed {
        logic       pie;
        logic [1:0] pplv;
    } prmd_t;

    typedef struct packed {
        logic [8:0]        esubcode;
        logic [5:0]        ecode;
        logic [`LIE_W-1:0] is;
    } estat_t;

    typedef struct packed {
        crmd_t                                    crmd;
        prmd_t                                    prmd;
        logic [`LIE_W-1:0]                        ecfg_lie;
        estat_t                                   estat;
        logic [`CSR_DATA_W-1:0]                   era;
        logic [`CSR_DATA_W-1:0]                   badv;
        logic [`CSR_DATA_W-`EENTRY_VA_LSB-1:0]    eentry_va;
        logic [3:0][`CSR_DATA_W-1:0]              save;
    } exc_state_t;

    typedef struct packed {
        logic [`CSR_DATA_W-1:0] tid;
        tcfg_view_t             tcfg;
        logic [`CSR_DATA_W-1:0] cnt;
    } timer_state_t;

endpackage

`default_nettype wire

//--- rtl/csr_read_mux.sv
`include "csr_config.svh"
`timescale 1ns/100ps
`default_nettype none

module csr_read_mux (
    input  csr_pkg::csr_sel_t      rsel,
    input  csr_pkg::exc_state_t    exc,
    input  csr_pkg::timer_state_t  tmr,
    output logic [`CSR_DATA_W-1:0] rval
);

    csr_pkg::csr_word_u crmd_w;
    csr_pkg::csr_word_u prmd_w;
    csr_pkg::csr_word_u estat_w;
    csr_pkg::csr_word_u tcfg_w;
    csr_pkg::csr_word_u ecfg_w;
    csr_pkg::csr_word_u eentry_w;

    always_comb begin
        crmd_w.raw            = '0;
        crmd_w.crmd.plv       = exc.crmd.plv;
        crmd_w.crmd.ie        = exc.crmd.ie;
        prmd_w.raw            = '0;
        prmd_w.prmd.pplv      = exc.prmd.pplv;
        prmd_w.prmd.pie       = exc.prmd.pie;
        // reserved bits stay zero
        estat_w.raw            = '0;
        estat_w.estat.is       = exc.estat.is;
        estat_w.estat.ecode    = exc.estat.ecode;
        estat_w.estat.esubcode = exc.estat.esubcode;
        tcfg_w.tcfg           = tmr.tcfg;
        ecfg_w.raw            = {{(`CSR_DATA_W-`LIE_W){1'b0}}, exc.ecfg_lie};
        eentry_w.raw          = {exc.eentry_va, {`EENTRY_VA_LSB{1'b0}}};
    end

    // ticlr has no read word
    assign rval = {`CSR_DATA_W{rsel.crmd}}   & crmd_w.raw
                | {`CSR_DATA_W{rsel.prmd}}   & prmd_w.raw
                | {`CSR_DATA_W{rsel.ecfg}}   & ecfg_w.raw
                | {`CSR_DATA_W{rsel.estat}}  & estat_w.raw
                | {`CSR_DATA_W{rsel.era}}    & exc.era
                | {`CSR_DATA_W{rsel.badv}}   & exc.badv
                | {`CSR_DATA_W{rsel.eentry}} & eentry_w.raw
                | {`CSR_DATA_W{rsel.save0}}  & exc.save[0]
                | {`CSR_DATA_W{rsel.save1}}  & exc.save[1]
                | {`CSR_DATA_W{rsel.save2}}  & exc.save[2]
                | {`CSR_DATA_W{rsel.save3}}  & exc.save[3]
                | {`CSR_DATA_W{rsel.tid}}    & tmr.tid
                | {`CSR_DATA_W{rsel.tcfg}}   & tcfg_w.raw
                | {`CSR_DATA_W{rsel.tval}}   & tmr.cnt;

endmodule

`default_nettype wire

//--- rtl/csr_timer.sv
`include "csr_config.svh"
`timescale 1ns/100ps
`default_nettype none

module csr_timer (
    input  logic                  clk,
    input  logic                  rst,
    input  csr_pkg::csr_wr_t      wr,
    input  csr_pkg::csr_sel_t     wsel,
    output csr_pkg::timer_state_t state,
    output logic                  timer_int
);

    csr_pkg::csr_word_u     wset;
    csr_pkg::csr_word_u     wkeep;
    csr_pkg::csr_word_u     tcfg_next;
    csr_pkg::tcfg_view_t    tcfg_q;
    logic [`CSR_DATA_W-1:0] tid_q;
    logic [`CSR_DATA_W-1:0] cnt_q;
    logic                   cnt_zero;
    logic                   ticlr_hit;

    assign wset.raw  = wr.wmask & wr.wval;
    assign wkeep.raw = ~wr.wmask;

    // tcfg after the pending write, used to start the counter
    assign tcfg_next.raw = wset.raw | wkeep.raw & tcfg_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            tid_q  <= '0;
            tcfg_q <= '0;
        end else begin
            if (wsel.tid) begin
                tid_q <= wset.raw | wkeep.raw & tid_q;
            end
            if (wsel.tcfg) begin
                tcfg_q <= tcfg_next.tcfg;
            end
        end
    end

    // all-ones means stopped
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '1;
        end else if (wsel.tcfg && tcfg_next.tcfg.en) begin
            cnt_q <= {tcfg_next.tcfg.initval, 2'b00};
        end else if (tcfg_q.en && cnt_q != '1) begin
            if (cnt_zero && tcfg_q.periodic) begin
                cnt_q <= {tcfg_q.initval, 2'b00};
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    assign cnt_zero  = cnt_q == '0;
    assign ticlr_hit = wsel.ticlr && wset.raw[`TICLR_CLR_BIT];

    // a zero count wins over a clear
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_int <= 1'b0;
        end else if (cnt_zero) begin
            timer_int <= 1'b1;
        end else if (ticlr_hit) begin
            timer_int <= 1'b0;
        end
    end

    assign state.tid  = tid_q;
    assign state.tcfg = tcfg_q;
    assign state.cnt  = cnt_q;

endmodule

`default_nettype wire

//--- rtl/csr_top.sv
`include "csr_config.svh"
`timescale 1ns/100ps
`default_nettype none

module csr_top (
    input  logic                   clk,
    input  logic                   rst,
    input  csr_pkg::csr_wr_t       wr,
    input  logic [`CSR_NUM_W-1:0]  rnum,
    output logic [`CSR_DATA_W-1:0] rval,
    input  csr_pkg::exc_commit_t   commit,
    input  logic                   ertn,
    output logic                   has_int,
    output logic [`CSR_DATA_W-1:0] exc_entry,
    output logic [`CSR_DATA_W-1:0] exc_retaddr,
    output logic [1:0]             crmd_plv
);

    csr_pkg::csr_sel_t     wsel;
    csr_pkg::csr_sel_t     rsel;
    csr_pkg::exc_state_t   exc_state;
    csr_pkg::timer_state_t tmr_state;
    logic                  timer_int;

    csr_decode i_csr_decode (
        .wr_en (wr.we),
        .wnum  (wr.wnum),
        .rnum  (rnum),
        .wsel  (wsel),
        .rsel  (rsel)
    );

    csr_exc_state i_csr_exc_state (
        .clk         (clk),
        .rst         (rst),
        .wr          (wr),
        .wsel        (wsel),
        .commit      (commit),
        .ertn        (ertn),
        .timer_int   (timer_int),
        .state       (exc_state),
        .has_int     (has_int),
        .exc_entry   (exc_entry),
        .exc_retaddr (exc_retaddr),
        .crmd_plv    (crmd_plv)
    );

    csr_timer i_csr_timer (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .wsel      (wsel),
        .state     (tmr_state),
        .timer_int (timer_int)
    );

    csr_read_mux i_csr_read_mux (
        .rsel (rsel),
        .exc  (exc_state),
        .tmr  (tmr_state),
        .rval (rval)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the csr testbench with verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module csr_tb -o csr_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/csr_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation run failed"
    exit 1
fi

if grep -q "Finished with errors" sim.log; then
    echo "FAIL"
    exit 1
fi

echo "PASS"
exit 0

//--- sources.f
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_decode.sv
rtl/csr_exc_state.sv
rtl/csr_timer.sv
rtl/csr_read_mux.sv
rtl/csr_top.sv
verification/csr_tb.sv

//--- verification/csr_tb.sv
`include "csr_config.svh"
`timescale 1ns/100ps
`default_nettype none

module csr_tb;

    logic                   clk;
    logic                   rst;
    csr_pkg::csr_wr_t       wr;
    logic [`CSR_NUM_W-1:0]  rnum;
    logic [`CSR_DATA_W-1:0] rval;
    csr_pkg::exc_commit_t   commit;
    logic                   ertn;
    logic                   has_int;
    logic [`CSR_DATA_W-1:0] exc_entry;
    logic [`CSR_DATA_W-1:0] exc_retaddr;
    logic [1:0]             crmd_plv;

    int    tests;
    int    checks;
    int    errors;
    int    test_errs;
    string test_name;

    // reference model of the registers
    logic [31:0] m_save [4];
    logic [31:0] m_era;
    logic [31:0] m_ecfg;
    logic [31:0] m_eentry;
    logic [31:0] m_badv;
    logic [2:0]  m_crmd;
    logic [2:0]  m_prmd;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esub;
    logic [1:0]  m_is_sw;
    logic        m_tint;

    logic [31:0] pc;
    logic [31:0] bad;

    csr_top i_csr_top (
        .clk         (clk),
        .rst         (rst),
        .wr          (wr),
        .rnum        (rnum),
        .rval        (rval),
        .commit      (commit),
        .ertn        (ertn),
        .has_int     (has_int),
        .exc_entry   (exc_entry),
        .exc_retaddr (exc_retaddr),
        .crmd_plv    (crmd_plv)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // a commit drops to plv 0 and returns to the faulting pc one edge later
    assert property (@(posedge clk) disable iff (rst)
                     commit.exc |=> crmd_plv == 2'b00 && exc_retaddr == $past(commit.pc))
        else begin
            $display("exception commit did not clear plv or record the return address");
            errors++;
            test_errs++;
        end

    function automatic logic [31:0] masked_merge(input logic [31:0] old,
                                                 input logic [31:0] mask,
                                                 input logic [31:0] val);
        return (old & ~mask) | (val & mask);
    endfunction

    function automatic logic [12:0] model_is();
        logic [12:0] is_bits;
        is_bits = '0;
        is_bits[1:0] = m_is_sw;
        is_bits[`TIMER_IS_BIT] = m_tint;
        return is_bits;
    endfunction

    function automatic logic [31:0] estat_word();
        return {1'b0, m_esub, m_ecode, 3'b000, model_is()};
    endfunction

    function automatic logic model_has_int();
        return (|(model_is() & m_ecfg[12:0])) & m_crmd[2];
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp)
            else begin
                $display("** Error: %s %s expected %h actual %h", test_name, what, exp, act);
                errors++;
                test_errs++;
            end
    endtask

    // called just after a falling edge, registers are stable until the next rise
    task automatic read_csr(input logic [13:0] num, output logic [31:0] val);
        rnum = num;
        #1;
        val = rval;
    endtask

    task automatic read_check(input string what, input logic [13:0] num, input logic [31:0] exp);
        logic [31:0] val;
        read_csr(num, val);
        check(what, exp, val);
    endtask

    task automatic write_csr(input logic [13:0] num, input logic [31:0] mask,
                             input logic [31:0] val);
        @(negedge clk);
        wr.we    = 1'b1;
        wr.wnum  = num;
        wr.wmask = mask;
        wr.wval  = val;
        @(negedge clk);
        wr.we = 1'b0;
    endtask

    task automatic commit_exc(input logic [5:0] ecode, input logic [8:0] esub,
                              input logic [31:0] epc, input logic [31:0] addr);
        @(negedge clk);
        commit.exc      = 1'b1;
        commit.ecode    = ecode;
        commit.esubcode = esub;
        commit.pc       = epc;
        commit.badvaddr = addr;
        @(negedge clk);
        commit.exc = 1'b0;
        m_prmd  = m_crmd;
        m_crmd  = 3'b000;
        m_era   = epc;
        m_ecode = ecode;
        m_esub  = esub;
        if (ecode == `ECODE_ADE && esub == `ESUBCODE_ADEF) begin
            m_badv = epc;
        end else if (ecode == `ECODE_ALE) begin
            m_badv = addr;
        end
    endtask

    task automatic masked_rw(input logic [13:0] num, input logic [31:0] keep_bits,
                             inout logic [31:0] model);
        logic [31:0] mask;
        logic [31:0] val;
        mask = $urandom;
        val  = $urandom;
        write_csr(num, mask, val);
        model = masked_merge(model, mask, val) & keep_bits;
        read_check($sformatf("readback of csr %h", num), num, model);
    endtask

    task automatic wait_tval_zero(input int limit);
        logic [31:0] v;
        int n;
        n = 0;
        read_csr(`CSR_TVAL, v);
        while (v != 0 && n < limit) begin
            @(negedge clk);
            read_csr(`CSR_TVAL, v);
            n++;
        end
        if (v != 0) begin
            $display("timeout in %s, timer value never reached zero", test_name);
            errors++;
            test_errs++;
        end
    endtask

    task automatic begin_test(input string name);
        @(negedge clk);
        test_name = name;
        test_errs = 0;
        tests++;
    endtask

    task automatic end_test();
        $display("test %s: %s (%0d errors)", test_name, test_errs == 0 ? "pass" : "FAIL",
                 test_errs);
    endtask

    initial begin
        void'($urandom(32'hd4e6));
        tests     = 0;
        checks    = 0;
        errors    = 0;
        test_errs = 0;
        rst       = 1'b1;
        wr        = '0;
        rnum      = '0;
        commit    = '0;
        ertn      = 1'b0;
        for (int i = 0; i < 4; i++) begin
            m_save[i] = '0;
        end
        m_era    = '0;
        m_ecfg   = '0;
        m_eentry = '0;
        m_badv   = '0;
        m_crmd   = '0;
        m_prmd   = '0;
        m_ecode  = '0;
        m_esub   = '0;
        m_is_sw  = '0;
        m_tint   = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        begin_test("reset");
        check("has_int", 0, 32'(has_int));
        check("crmd_plv", 0, 32'(crmd_plv));
        read_check("crmd", `CSR_CRMD, 0);
        read_check("estat", `CSR_ESTAT, 0);
        read_check("tval", `CSR_TVAL, 32'hffff_ffff);
        end_test();

        begin_test("masked_write");
        for (int r = 0; r < 6; r++) begin
            for (int i = 0; i < 4; i++) begin
                masked_rw(14'(`CSR_SAVE0 + i), 32'hffff_ffff, m_save[i]);
            end
            masked_rw(`CSR_ERA, 32'hffff_ffff, m_era);
            masked_rw(`CSR_ECFG, 32'h0000_1fff, m_ecfg);
            masked_rw(`CSR_EENTRY, 32'hffff_ffc0, m_eentry);
        end
        read_check("unused number", 14'h0ff, 0);
        read_check("ticlr", `CSR_TICLR, 0);
        end_test();

        begin_test("exception_entry");
        write_csr(`CSR_CRMD, 32'h7, 32'h7);
        m_crmd = 3'h7;
        read_check("crmd set", `CSR_CRMD, 32'h7);
        pc  = $urandom & ~32'h3;
        bad = $urandom;
        commit_exc(6'h0b, 9'h000, pc, bad);
        check("crmd_plv", 0, 32'(crmd_plv));
        read_check("crmd", `CSR_CRMD, 32'(m_crmd));
        read_check("prmd", `CSR_PRMD, 32'(m_prmd));
        read_check("era", `CSR_ERA, m_era);
        read_check("estat", `CSR_ESTAT, estat_word());
        check("exc_entry", m_eentry, exc_entry);
        check("exc_retaddr", m_era, exc_retaddr);
        end_test();

        begin_test("badv_capture");
        read_check("badv before", `CSR_BADV, m_badv);
        commit_exc(`ECODE_ALE, 9'h000, $urandom & ~32'h3, $urandom);
        read_check("ale badv", `CSR_BADV, m_badv);
        commit_exc(`ECODE_ADE, `ESUBCODE_ADEF, $urandom & ~32'h3, $urandom);
        read_check("adef badv", `CSR_BADV, m_badv);
        commit_exc(6'h0b, 9'h000, $urandom & ~32'h3, $urandom);
        read_check("badv kept", `CSR_BADV, m_badv);
        end_test();

        begin_test("exception_return");
        write_csr(`CSR_PRMD, 32'h7, 32'h6);
        m_prmd = 3'h6;
        // software crmd write in the same cycle loses to ertn
        wr.we    = 1'b1;
        wr.wnum  = `CSR_CRMD;
        wr.wmask = 32'h7;
        wr.wval  = 32'h3;
        ertn     = 1'b1;
        @(negedge clk);
        wr.we  = 1'b0;
        ertn   = 1'b0;
        m_crmd = m_prmd;
        check("crmd_plv", 32'(m_crmd[1:0]), 32'(crmd_plv));
        read_check("crmd", `CSR_CRMD, 32'(m_crmd));
        end_test();

        begin_test("timer");
        write_csr(`CSR_ECFG, 32'hffff_ffff, 32'h0);
        m_ecfg = '0;
        write_csr(`CSR_ESTAT, 32'h3, 32'h0);
        m_is_sw = '0;
        write_csr(`CSR_TCFG, 32'hffff_ffff, (32'd3 << 2) | 32'h1);
        read_check("tval load", `CSR_TVAL, 32'd12);
        for (int i = 1; i <= 3; i++) begin
            @(negedge clk);
            read_check("tval count", `CSR_TVAL, 32'd12 - 32'(i));
        end
        wait_tval_zero(64);
        read_check("estat at zero count", `CSR_ESTAT, estat_word());
        @(negedge clk);
        m_tint = 1'b1;
        read_check("estat timer bit", `CSR_ESTAT, estat_word());
        read_check("tval stopped", `CSR_TVAL, 32'hffff_ffff);
        check("has_int ecfg off", 32'(model_has_int()), 32'(has_int));
        write_csr(`CSR_ECFG, 32'h800, 32'h800);
        m_ecfg = 32'h800;
        check("has_int enabled", 32'(model_has_int()), 32'(has_int));
        write_csr(`CSR_CRMD, 32'h4, 32'h0);
        m_crmd[2] = 1'b0;
        check("has_int ie off", 32'(model_has_int()), 32'(has_int));
        write_csr(`CSR_CRMD, 32'h4, 32'h4);
        m_crmd[2] = 1'b1;
        check("has_int ie on", 32'(model_has_int()), 32'(has_int));
        write_csr(`CSR_TICLR, 32'h1, 32'h1);
        m_tint = 1'b0;
        read_check("estat cleared", `CSR_ESTAT, estat_word());
        check("has_int cleared", 32'(model_has_int()), 32'(has_int));
        // periodic reload
        write_csr(`CSR_TCFG, 32'hffff_ffff, (32'd2 << 2) | 32'h3);
        read_check("tval periodic load", `CSR_TVAL, 32'd8);
        wait_tval_zero(64);
        @(negedge clk);
        m_tint = 1'b1;
        read_check("tval reload", `CSR_TVAL, 32'd8);
        check("has_int periodic", 32'(model_has_int()), 32'(has_int));
        write_csr(`CSR_TCFG, 32'hffff_ffff, 32'h0);
        write_csr(`CSR_TICLR, 32'h1, 32'h1);
        m_tint = 1'b0;
        read_check("estat after stop", `CSR_ESTAT, estat_word());
        end_test();

        begin_test("software_interrupt");
        write_csr(`CSR_ECFG, 32'hffff_ffff, 32'h3);
        m_ecfg = 32'h3;
        write_csr(`CSR_ESTAT, 32'h3, 32'h1);
        m_is_sw = 2'b01;
        read_check("estat", `CSR_ESTAT, estat_word());
        check("has_int raised", 32'(model_has_int()), 32'(has_int));
        write_csr(`CSR_ECFG, 32'h1, 32'h0);
        m_ecfg = 32'h2;
        check("has_int enable off", 32'(model_has_int()), 32'(has_int));
        write_csr(`CSR_ECFG, 32'h1, 32'h1);
        m_ecfg = 32'h3;
        check("has_int enable on", 32'(model_has_int()), 32'(has_int));
        write_csr(`CSR_CRMD, 32'h4, 32'h0);
        m_crmd[2] = 1'b0;
        check("has_int ie off", 32'(model_has_int()), 32'(has_int));
        end_test();

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
